// ==== hdl/cache_consts.svh ====
// Cache geometry and data width macros
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// ------------------------------
// Geometry
// ------------------------------
`define CACHE_SETS      4
`define CACHE_WAYS      2   // One LRU bit per set covers exactly two ways
`define WORDS_PER_LINE  4

// ------------------------------
// Widths
// ------------------------------
`define WORD_W          32
`define LINE_W          128  // WORDS_PER_LINE * WORD_W
`define PROC_ADDR_W     30   // Word address from the processor

`endif

// ==== hdl/cache_pkg.sv ====
// Cache vector types and miss controller state encoding
`include "cache_consts.svh"

package cache_pkg;

    // Data
    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`LINE_W-1:0] line_t;

    // Address fields as tag | set | word offset
    typedef logic [`PROC_ADDR_W-1:0] proc_addr_t;
    typedef logic [$clog2(`WORDS_PER_LINE)-1:0] word_off_t;
    typedef logic [$clog2(`CACHE_SETS)-1:0] set_idx_t;
    typedef logic [`PROC_ADDR_W-$clog2(`WORDS_PER_LINE)-1:0] line_addr_t;
    typedef logic [`PROC_ADDR_W-$clog2(`WORDS_PER_LINE)-$clog2(`CACHE_SETS)-1:0] tag_t;

    // Miss controller
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,   // Dirty victim going out
        ST_REFILL       // Waiting for the new line
    } miss_state_e;

endpackage

// ==== hdl/line_update_if.sv ====
// Line fill and word write command bus from the miss controller to the arrays
`timescale 1ns/1ps

interface line_update_if;
    import cache_pkg::*;

    logic      wr_word;     // Word write into a present line
    logic      fill_line;   // Whole line load after a refill
    logic      way;
    set_idx_t  set_idx;
    word_off_t word_off;
    tag_t      tag;         // New tag on a fill
    word_t     wdata;
    line_t     ldata;

    // Controller side
    modport ctrl (
        output wr_word, fill_line, way, set_idx, word_off, tag, wdata, ldata
    );

    // Tag array and data array side
    modport array (
        input  wr_word, fill_line, way, set_idx, word_off, tag, wdata, ldata
    );

endinterface

// ==== hdl/cache_tag_array.sv ====
// Valid, dirty, tag and LRU storage with hit detection and victim choice
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tag_array (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  cache_pkg::proc_addr_t i_proc_addr,
    input  logic                  i_access,
    output logic                  o_hit,
    output logic                  o_hit_way,
    output logic                  o_victim_way,
    output logic                  o_victim_dirty,
    output cache_pkg::tag_t       o_victim_tag,
    line_update_if.array          upd
);
    import cache_pkg::*;

    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid;
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty;
    logic [`CACHE_SETS-1:0]                  lru;    // Way used last, per set
    tag_t                                    tags [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]                  way_hit;
    tag_t                                    addr_tag;
    set_idx_t                                set_idx;

    assign set_idx  = i_proc_addr[$bits(word_off_t) +: $bits(set_idx_t)];
    assign addr_tag = i_proc_addr[`PROC_ADDR_W-1 -: $bits(tag_t)];

    // ------------------------------
    // Lookup
    // ------------------------------
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = valid[w][set_idx] && (tags[w][set_idx] == addr_tag);
        end
    end

    assign o_hit     = |way_hit;
    assign o_hit_way = way_hit[1];

    // Victim is the way not touched last
    assign o_victim_way   = ~lru[set_idx];
    assign o_victim_dirty = valid[o_victim_way][set_idx] & dirty[o_victim_way][set_idx];
    assign o_victim_tag   = tags[o_victim_way][set_idx];

    // ------------------------------
    // Updates
    // ------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (upd.fill_line) begin
                valid[upd.way][upd.set_idx] <= 1'b1;
                dirty[upd.way][upd.set_idx] <= 1'b0;    // Fresh line matches memory
            end else if (upd.wr_word) begin
                dirty[upd.way][upd.set_idx] <= 1'b1;
            end
            if (i_access && o_hit)
                lru[set_idx] <= o_hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.fill_line)
            tags[upd.way][upd.set_idx] <= upd.tag;
    end

endmodule

// ==== hdl/cache_data_array.sv ====
// Line storage for both ways with word read, word write and line fill
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_data_array (
    input  logic                  clk,
    input  cache_pkg::proc_addr_t i_proc_addr,
    input  logic                  i_hit_way,
    input  logic                  i_victim_way,
    output cache_pkg::word_t      o_rdata,
    output cache_pkg::line_t      o_victim_line,
    line_update_if.array          upd
);
    import cache_pkg::*;

    line_t     lines [`CACHE_WAYS][`CACHE_SETS];
    set_idx_t  set_idx;
    word_off_t word_off;

    assign word_off = i_proc_addr[0 +: $bits(word_off_t)];
    assign set_idx  = i_proc_addr[$bits(word_off_t) +: $bits(set_idx_t)];

    // ------------------------------
    // Read side
    // ------------------------------
    assign o_rdata       = lines[i_hit_way][set_idx][word_off*`WORD_W +: `WORD_W];
    assign o_victim_line = lines[i_victim_way][set_idx];   // Outgoing line on write-back

    // ------------------------------
    // Write side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (upd.fill_line) begin
            lines[upd.way][upd.set_idx] <= upd.ldata;
        end else if (upd.wr_word) begin
            // Single word into an already present line
            lines[upd.way][upd.set_idx][upd.word_off*`WORD_W +: `WORD_W] <= upd.wdata;
        end
    end

endmodule

// ==== hdl/cache_miss_fsm.sv ====
// Miss controller with stall, memory request registers, write-back and refill
`timescale 1ns/1ps

module cache_miss_fsm (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_proc_read,
    input  logic                  i_proc_write,
    input  cache_pkg::proc_addr_t i_proc_addr,
    input  cache_pkg::word_t      i_proc_wdata,
    input  logic                  i_hit,
    input  logic                  i_hit_way,
    input  logic                  i_victim_way,
    input  logic                  i_victim_dirty,
    input  cache_pkg::tag_t       i_victim_tag,
    input  cache_pkg::line_t      i_victim_line,
    input  cache_pkg::line_t      i_mem_rdata,
    input  logic                  i_mem_ready,
    output logic                  o_proc_stall,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output cache_pkg::line_addr_t o_mem_addr,
    output cache_pkg::line_t      o_mem_wdata,
    line_update_if.ctrl           upd
);
    import cache_pkg::*;

    miss_state_e state;
    miss_state_e state_nxt;
    tag_t        req_tag;
    set_idx_t    req_set;
    word_off_t   req_off;
    logic        req_valid;
    logic        miss;
    logic        wr_word;
    logic        fill_line;

    assign {req_tag, req_set, req_off} = i_proc_addr;

    assign req_valid    = i_proc_read | i_proc_write;
    assign miss         = req_valid & ~i_hit;
    assign o_proc_stall = miss;     // Held request stays stalled until it hits

    // ------------------------------
    // Array update commands
    // ------------------------------
    assign wr_word   = (state == ST_IDLE) & i_proc_write & i_hit;
    assign fill_line = (state == ST_REFILL) & i_mem_ready;

    assign upd.wr_word   = wr_word;
    assign upd.fill_line = fill_line;
    assign upd.way       = wr_word ? i_hit_way : i_victim_way;  // LRU is frozen during a miss
    assign upd.set_idx   = req_set;
    assign upd.word_off  = req_off;
    assign upd.tag       = req_tag;
    assign upd.wdata     = i_proc_wdata;
    assign upd.ldata     = i_mem_rdata;

    // ------------------------------
    // State sequencing
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (miss)
                    state_nxt = i_victim_dirty ? ST_WRITEBACK : ST_REFILL;
            end
            ST_WRITEBACK: begin
                if (i_mem_ready)
                    state_nxt = ST_REFILL;
            end
            ST_REFILL: begin
                if (i_mem_ready)
                    state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else begin
            state <= state_nxt;
            case (state)
                ST_IDLE: begin
                    if (miss) begin
                        o_mem_write <= i_victim_dirty;
                        o_mem_read  <= ~i_victim_dirty;
                    end
                end
                ST_WRITEBACK: begin
                    if (i_mem_ready) begin  // Refill request starts on the same edge
                        o_mem_write <= 1'b0;
                        o_mem_read  <= 1'b1;
                    end
                end
                ST_REFILL: begin
                    if (i_mem_ready)
                        o_mem_read <= 1'b0;
                end
                default: begin
                    o_mem_read  <= 1'b0;
                    o_mem_write <= 1'b0;
                end
            endcase
        end
    end

    // Memory address and line stay stable while a request is pending
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && miss) begin
            o_mem_addr  <= i_victim_dirty ? {i_victim_tag, req_set} : {req_tag, req_set};
            o_mem_wdata <= i_victim_line;
        end else if (state == ST_WRITEBACK && i_mem_ready) begin
            o_mem_addr  <= {req_tag, req_set};
        end
    end

endmodule

// ==== hdl/cache_core.sv ====
// Two-way write-back cache top level with processor and memory ports
`timescale 1ns/1ps

module cache_core (
    input  logic                  clk,
    input  logic                  i_rst_n,
    // Processor side
    input  logic                  i_proc_read,
    input  logic                  i_proc_write,
    input  cache_pkg::proc_addr_t i_proc_addr,
    input  cache_pkg::word_t      i_proc_wdata,
    output logic                  o_proc_stall,
    output cache_pkg::word_t      o_proc_rdata,
    // Memory side
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output cache_pkg::line_addr_t o_mem_addr,
    output cache_pkg::line_t      o_mem_wdata,
    input  cache_pkg::line_t      i_mem_rdata,
    input  logic                  i_mem_ready
);
    import cache_pkg::*;

    line_update_if upd_bus ();

    logic  hit;
    logic  hit_way;
    logic  victim_way;
    logic  victim_dirty;
    tag_t  victim_tag;
    line_t victim_line;
    word_t array_rdata;

    assign o_proc_rdata = (i_proc_read && hit) ? array_rdata : '0;

    cache_miss_fsm u_miss_fsm (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_proc_read    (i_proc_read),
        .i_proc_write   (i_proc_write),
        .i_proc_addr    (i_proc_addr),
        .i_proc_wdata   (i_proc_wdata),
        .i_hit          (hit),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .i_victim_line  (victim_line),
        .i_mem_rdata    (i_mem_rdata),
        .i_mem_ready    (i_mem_ready),
        .o_proc_stall   (o_proc_stall),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata),
        .upd            (upd_bus.ctrl)
    );

    cache_tag_array u_tag_array (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_proc_addr    (i_proc_addr),
        .i_access       (i_proc_read | i_proc_write),   // LRU follows real accesses only
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag),
        .upd            (upd_bus.array)
    );

    cache_data_array u_data_array (
        .clk            (clk),
        .i_proc_addr    (i_proc_addr),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .o_rdata        (array_rdata),
        .o_victim_line  (victim_line),
        .upd            (upd_bus.array)
    );

endmodule

// ==== tb/slow_mem.sv ====
// Behavioral line memory with random ready delay and a readable shadow store
`timescale 1ns/1ps
`include "cache_consts.svh"

module slow_mem #(
    parameter logic [31:0] FILL_BASE = 32'h0A00_0000,
    parameter int          MAX_DELAY = 6,
    parameter int          SEED      = 72
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_read,
    input  logic                  i_write,
    input  cache_pkg::line_addr_t i_addr,
    input  cache_pkg::line_t      i_wdata,
    output cache_pkg::line_t      o_rdata,
    output logic                  o_ready
);
    import cache_pkg::*;

    line_t store [line_addr_t];     // Lines written back so far
    logic  busy;
    int    wait_left;
    int    delay;

    initial begin
        void'($urandom(SEED));
    end

    // Lines never written hold the fill rule
    function automatic line_t peek_line(line_addr_t addr);
        line_t line;
        if (store.exists(addr))
            return store[addr];
        for (int w = 0; w < `WORDS_PER_LINE; w++)
            line[w*`WORD_W +: `WORD_W] = {addr, 4'h0} + word_t'(w) + FILL_BASE;
        return line;
    endfunction

    task automatic respond();
        if (i_write)
            store[i_addr] = i_wdata;
        else
            o_rdata <= peek_line(i_addr);
        o_ready <= 1'b1;
    endtask

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy      <= 1'b0;
            wait_left <= 0;
            o_ready   <= 1'b0;
            o_rdata   <= '0;
        end else if (o_ready) begin
            busy    <= 1'b0;        // Request drops or changes after the pulse
            o_ready <= 1'b0;
        end else if (busy) begin
            if (wait_left == 1)
                respond();
            else
                wait_left <= wait_left - 1;
        end else if (i_read || i_write) begin
            delay = 1 + int'($urandom % MAX_DELAY);
            if (delay == 1) begin
                respond();
            end else begin
                busy      <= 1'b1;
                wait_left <= delay - 1;
            end
        end
    end

endmodule

// ==== tb/cache_tb.sv ====
// Cache testbench with stimulus table, reference model, memory monitor and watchdog
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 8;
    localparam int          NUM_ROWS     = 14;
    localparam int          MAX_DELAY    = 6;
    localparam int          ROW_CYCLES   = 2 * MAX_DELAY + 4;  // Write-back plus refill
    localparam int          RESET_NS     = (RESET_CYCLES + 1) * CLK_PERIOD;
    localparam int          WATCHDOG_NS  = NUM_ROWS * ROW_CYCLES * CLK_PERIOD + RESET_NS;
    localparam logic [31:0] FILL_BASE    = 32'h0A00_0000;
    localparam int          RD           = 0;
    localparam int          WR           = 1;

    typedef struct {
        string      name;
        bit         is_write;
        proc_addr_t addr;
        line_addr_t line_addr;
        word_t      wdata;
        word_t      exp_rdata;
        bit         exp_refill;
        bit         exp_wb;
        line_addr_t exp_wb_addr;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       proc_read;
    logic       proc_write;
    proc_addr_t proc_addr;
    word_t      proc_wdata;
    logic       proc_stall;
    word_t      proc_rdata;
    logic       mem_read;
    logic       mem_write;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_ready;

    row_t       rows [NUM_ROWS];
    int         row_count   = 0;
    int         row_errors  = 0;
    int         pass_count  = 0;
    int         fail_count  = 0;
    word_t      written [proc_addr_t];  // Every word the testbench stored
    int         req_cycles  = 0;
    int         read_done   = 0;
    int         write_done  = 0;
    line_addr_t last_rd_addr;
    line_addr_t last_wb_addr;
    line_t      last_wb_data;

    cache_core dut (
        .clk (clk), .i_rst_n (rst_n),
        .i_proc_read (proc_read), .i_proc_write (proc_write),
        .i_proc_addr (proc_addr), .i_proc_wdata (proc_wdata),
        .o_proc_stall (proc_stall), .o_proc_rdata (proc_rdata),
        .o_mem_read (mem_read), .o_mem_write (mem_write),
        .o_mem_addr (mem_addr), .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata), .i_mem_ready (mem_ready)
    );

    slow_mem #(.FILL_BASE (FILL_BASE), .MAX_DELAY (MAX_DELAY), .SEED (72)) mem (
        .clk (clk), .i_rst_n (rst_n),
        .i_read (mem_read), .i_write (mem_write),
        .i_addr (mem_addr), .i_wdata (mem_wdata),
        .o_rdata (mem_rdata), .o_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Memory bus monitor records each completed handshake
    always @(posedge clk) begin
        if (mem_read || mem_write)
            req_cycles <= req_cycles + 1;
        if (mem_ready && mem_read) begin
            read_done    <= read_done + 1;
            last_rd_addr <= mem_addr;
        end
        if (mem_ready && mem_write) begin
            write_done   <= write_done + 1;
            last_wb_addr <= mem_addr;
            last_wb_data <= mem_wdata;
        end
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic proc_addr_t word_at(int tag_n, int set_n, int off_n);
        return {tag_t'(tag_n), set_idx_t'(set_n), word_off_t'(off_n)};
    endfunction

    function automatic word_t init_word(proc_addr_t addr);
        line_addr_t line_addr;
        word_off_t  off;
        {line_addr, off} = addr;
        return {line_addr, 4'h0} + word_t'(off) + FILL_BASE;   // L * 16 + w + base
    endfunction

    function automatic word_t model_word(proc_addr_t addr);
        if (written.exists(addr))
            return written[addr];
        return init_word(addr);
    endfunction

    function automatic line_t model_line(line_addr_t line_addr);
        line_t line;
        for (int w = 0; w < `WORDS_PER_LINE; w++)
            line[w*`WORD_W +: `WORD_W] = model_word({line_addr, word_off_t'(w)});
        return line;
    endfunction

    // ------------------------------
    // Table and row runner
    // ------------------------------
    task automatic add_row(input string name, input int wr, input int tag_n, input int set_n,
                           input int off_n, input word_t wdata, input word_t exp_rdata,
                           input int refill, input int wb, input int wb_tag);
        rows[row_count].name        = name;
        rows[row_count].is_write    = (wr != 0);
        rows[row_count].addr        = word_at(tag_n, set_n, off_n);
        rows[row_count].line_addr   = {tag_t'(tag_n), set_idx_t'(set_n)};
        rows[row_count].wdata       = wdata;
        rows[row_count].exp_rdata   = exp_rdata;
        rows[row_count].exp_refill  = (refill != 0);
        rows[row_count].exp_wb      = (wb != 0);
        rows[row_count].exp_wb_addr = {tag_t'(wb_tag), set_idx_t'(set_n)};
        row_count++;
    endtask

    task automatic build_table();
        add_row("rd_miss_s0",  RD, 5, 0, 2, '0, init_word(word_at(5, 0, 2)), 1, 0, 0);
        add_row("rd_hit_s0",   RD, 5, 0, 3, '0, init_word(word_at(5, 0, 3)), 0, 0, 0);
        add_row("wr_hit_s0",   WR, 5, 0, 1, 32'hDEAD_0001, '0, 0, 0, 0);
        add_row("rd_after_wr", RD, 5, 0, 1, '0, 32'hDEAD_0001, 0, 0, 0);
        add_row("rd_neighbor", RD, 5, 0, 0, '0, init_word(word_at(5, 0, 0)), 0, 0, 0);
        add_row("wr_miss_s2",  WR, 9, 2, 3, 32'hCAFE_0203, '0, 1, 0, 0);
        add_row("rd_wr_miss",  RD, 9, 2, 3, '0, 32'hCAFE_0203, 0, 0, 0);
        add_row("fill_way_a",  WR, 3, 1, 0, 32'hBEEF_0300, '0, 1, 0, 0);
        add_row("fill_way_b",  WR, 4, 1, 2, 32'hBEEF_0402, '0, 1, 0, 0);
        add_row("touch_a",     RD, 3, 1, 0, '0, 32'hBEEF_0300, 0, 0, 0);
        add_row("evict_b",     RD, 7, 1, 1, '0, init_word(word_at(7, 1, 1)), 1, 1, 4);
        add_row("reload_b",    RD, 4, 1, 2, '0, 32'hBEEF_0402, 1, 1, 3);
        add_row("reload_a",    RD, 3, 1, 0, '0, 32'hBEEF_0300, 1, 0, 0);
        add_row("rd_b_word",   RD, 4, 1, 3, '0, init_word(word_at(4, 1, 3)), 0, 0, 0);
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input line_t exp, input line_t act);
        $display("** Error %s %s: expected %0h, actual %0h", name, what, exp, act);
        row_errors++;
    endtask

    task automatic run_row(input int idx);
        row_t  row;
        int    reqs0;
        int    reads0;
        int    writes0;
        word_t got;
        row = rows[idx];
        row_errors = 0;
        @(negedge clk);
        reqs0      = req_cycles;
        reads0     = read_done;
        writes0    = write_done;
        proc_read  = !row.is_write;
        proc_write = row.is_write;
        proc_addr  = row.addr;
        proc_wdata = row.wdata;
        do
            @(posedge clk);
        while (proc_stall);
        got = proc_rdata;
        if (!row.is_write) begin
            assert (got == row.exp_rdata)
                else report_mismatch(row.name, "rdata", line_t'(row.exp_rdata), line_t'(got));
            assert (got == model_word(row.addr))
                else report_mismatch(row.name, "model", line_t'(model_word(row.addr)),
                                     line_t'(got));
        end
        assert ((read_done != reads0) == row.exp_refill)
            else report_mismatch(row.name, "refill", line_t'(row.exp_refill),
                                 line_t'(read_done != reads0));
        if (row.exp_refill) begin
            assert (last_rd_addr == row.line_addr)
                else report_mismatch(row.name, "refill addr", line_t'(row.line_addr),
                                     line_t'(last_rd_addr));
        end else begin
            assert (req_cycles == reqs0)
                else report_mismatch(row.name, "mem requests", '0, line_t'(req_cycles - reqs0));
        end
        assert ((write_done != writes0) == row.exp_wb)
            else report_mismatch(row.name, "write-back", line_t'(row.exp_wb),
                                 line_t'(write_done != writes0));
        if (row.exp_wb) begin
            assert (last_wb_addr == row.exp_wb_addr)
                else report_mismatch(row.name, "wb addr", line_t'(row.exp_wb_addr),
                                     line_t'(last_wb_addr));
            assert (last_wb_data == model_line(row.exp_wb_addr))
                else report_mismatch(row.name, "wb data", model_line(row.exp_wb_addr),
                                     last_wb_data);
            assert (mem.peek_line(row.exp_wb_addr) == model_line(row.exp_wb_addr))
                else report_mismatch(row.name, "mem line", model_line(row.exp_wb_addr),
                                     mem.peek_line(row.exp_wb_addr));
        end
        if (row.is_write)
            written[row.addr] = row.wdata;
        if (row_errors == 0)
            pass_count++;
        else
            fail_count++;
        $display("%s: %s", row.name, (row_errors == 0) ? "passed" : "FAILED");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n      = 1'b0;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        assert (!mem_read && !mem_write && !proc_stall) else begin
            $display("Memory request or stall active during reset");
            fail_count++;
        end
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished, the cache stayed stalled");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== cache_core.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/line_update_if.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_miss_fsm.sv
hdl/cache_core.sv
tb/slow_mem.sv
tb/cache_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing -Wall
TOP      = cache_tb
RTL_TOP  = cache_core
FLIST    = cache_core.f
OBJ_DIR  = obj_dir
PASS_MSG = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINT) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
